// File: rtl/freeList.sv
`timescale 1ns/100ps
`default_nettype none

module freeList (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [renamePkg::allocWidth-1:0]                        allocNum,
    input  logic                                                    fire,
    output logic                                                    short,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] allocPrd,
    input  logic [renamePkg::commitWidth-1:0]                       relValid,
    input  logic [renamePkg::commitWidth-1:0][renamePkg::pregWidth-1:0] relPrd
);
    import renamePkg::*;

    logic [pregWidth-1:0]  entries [freeDepth];
    logic [ptrWidth-1:0]   head;    // Next write slot
    logic [ptrWidth-1:0]   tail;    // Oldest free register
    logic [countWidth-1:0] count;
    logic [allocWidth-1:0] popNum;
    logic [countWidth-1:0] pushNum;
    logic [commitWidth-1:0][ptrWidth-1:0] relOff;

    assign short  = count < countWidth'(allocNum);
    assign popNum = fire ? allocNum : '0;

    generate
        for (genvar i = 0; i < renameWidth; i++) begin : gRead
            assign allocPrd[i] = entries[tail + ptrWidth'(i)];
        end
    endgenerate

    // Compact released lanes so they land in consecutive slots
    always_comb begin
        pushNum = '0;
        for (int i = 0; i < commitWidth; i++) begin
            relOff[i] = pushNum[ptrWidth-1:0];
            pushNum   = pushNum + countWidth'(relValid[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < freeDepth; i++) begin
                entries[i] <= pregWidth'(archRegs + i);
            end
            head  <= '0;    // Full buffer, head wraps onto tail
            tail  <= '0;
            count <= countWidth'(freeDepth);
        end else begin
            tail  <= tail + ptrWidth'(popNum);
            head  <= head + ptrWidth'(pushNum);
            count <= count - countWidth'(popNum) + pushNum;
            for (int i = 0; i < commitWidth; i++) begin
                if (relValid[i]) begin
                    entries[head + relOff[i]] <= relPrd[i];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= countWidth'(freeDepth))
        else $error("freeList: free count above depth");

    // Back-pressure from the free list must hold the group
    assert property (@(posedge clk) disable iff (rst) fire |-> !short)
        else $error("freeList: pop while short");

endmodule

`default_nettype wire

// File: rtl/mapTable.sv
`timescale 1ns/100ps
`default_nettype none

module mapTable (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [renamePkg::renameWidth-1:0]                       grpValid,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] grpRd,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] grpRs1,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] grpRs2,
    input  logic [renamePkg::renameWidth-1:0]                       grpHasRd,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] allocPrd,
    input  logic                                                    short,
    input  logic                                                    outReady,
    output logic                                                    fire,
    output logic [renamePkg::renameWidth-1:0]                       outValid,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] outPrd,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] outPrs1,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] outPrs2
);
    import renamePkg::*;

    logic [pregWidth-1:0] specMap [archRegs];
    logic [renameWidth-1:0] isDest;
    logic [renameWidth-1:0][allocWidth-1:0] allocIdx;

    assign isDest   = grpValid & grpHasRd;
    assign outValid = short ? '0 : grpValid;
    assign fire     = outValid[0] && outReady;

    always_comb begin
        allocIdx = '0;
        for (int i = 1; i < renameWidth; i++) begin
            allocIdx[i] = allocIdx[i-1] + allocWidth'(isDest[i-1]);  // Skip lanes without rd
        end
    end

    always_comb begin
        for (int i = 0; i < renameWidth; i++) begin
            outPrd[i]  = isDest[i] ? allocPrd[allocIdx[i]] : '0;
            outPrs1[i] = specMap[grpRs1[i]];
            outPrs2[i] = specMap[grpRs2[i]];
            // Older lanes in the group override the table, youngest match last
            for (int j = 0; j < i; j++) begin
                if (isDest[j] && grpRd[j] == grpRs1[i]) begin
                    outPrs1[i] = outPrd[j];
                end
                if (isDest[j] && grpRd[j] == grpRs2[i]) begin
                    outPrs2[i] = outPrd[j];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < archRegs; i++) begin
                specMap[i] <= pregWidth'(i);
            end
        end else if (fire) begin
            for (int i = 0; i < renameWidth; i++) begin
                if (isDest[i]) begin
                    specMap[grpRd[i]] <= outPrd[i];   // Later lane wins
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/renameInput.sv
`timescale 1ns/100ps
`default_nettype none

module renameInput (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [renamePkg::renameWidth-1:0]                       inValid,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] inRd,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] inRs1,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] inRs2,
    input  logic [renamePkg::renameWidth-1:0]                       inHasRd,
    output logic                                                    inReady,
    output logic [renamePkg::renameWidth-1:0]                       grpValid,
    output logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] grpRd,
    output logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] grpRs1,
    output logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] grpRs2,
    output logic [renamePkg::renameWidth-1:0]                       grpHasRd,
    output logic [renamePkg::allocWidth-1:0]                        allocNum,
    input  logic                                                    short,
    input  logic                                                    outReady
);
    import renamePkg::*;

    logic groupFire;
    logic take;

    assign groupFire = grpValid[0] && !short && outReady;  // Same condition as mapTable
    assign inReady   = !grpValid[0] || groupFire;
    assign take      = inValid[0] && inReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grpValid <= '0;
        end else if (take) begin
            grpValid <= inValid;
        end else if (groupFire) begin
            grpValid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            grpRd    <= inRd;
            grpRs1   <= inRs1;
            grpRs2   <= inRs2;
            grpHasRd <= inHasRd;
        end
    end

    // Destinations that need a fresh physical register
    always_comb begin
        allocNum = '0;
        for (int i = 0; i < renameWidth; i++) begin
            allocNum = allocNum + allocWidth'(grpValid[i] && grpHasRd[i]);
        end
    end

    assert property (@(posedge clk) disable iff (rst) inValid[1] |-> inValid[0])
        else $error("renameInput: lane 1 valid without lane 0");

endmodule

`default_nettype wire

// File: rtl/renamePkg.sv
`default_nettype none

package renamePkg;

    // Rename group and retire group widths
    localparam int renameWidth = 2;
    localparam int commitWidth = 2;

    // Register file sizes
    localparam int archRegs  = 32;
    localparam int pregCount = 64;
    localparam int aregWidth = 5;
    localparam int pregWidth = 6;

    // Free list geometry; physical registers 32..63 start out free
    localparam int freeDepth  = pregCount - archRegs;
    localparam int ptrWidth   = 5;
    localparam int countWidth = 6;   // Holds 0..freeDepth

    // Destinations per group, 0..renameWidth
    localparam int allocWidth = 2;

endpackage

`default_nettype wire

// File: rtl/renameTop.sv
`timescale 1ns/100ps
`default_nettype none

module renameTop (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [renamePkg::renameWidth-1:0]                       inValid,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] inRd,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] inRs1,
    input  logic [renamePkg::renameWidth-1:0][renamePkg::aregWidth-1:0] inRs2,
    input  logic [renamePkg::renameWidth-1:0]                       inHasRd,
    output logic                                                    inReady,
    output logic [renamePkg::renameWidth-1:0]                       outValid,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] outPrd,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] outPrs1,
    output logic [renamePkg::renameWidth-1:0][renamePkg::pregWidth-1:0] outPrs2,
    input  logic                                                    outReady,
    input  logic [renamePkg::commitWidth-1:0]                       cmtValid,
    input  logic [renamePkg::commitWidth-1:0][renamePkg::aregWidth-1:0] cmtRd,
    input  logic [renamePkg::commitWidth-1:0][renamePkg::pregWidth-1:0] cmtPrd
);
    import renamePkg::*;

    logic [renameWidth-1:0]                 grpValid;
    logic [renameWidth-1:0][aregWidth-1:0]  grpRd;
    logic [renameWidth-1:0][aregWidth-1:0]  grpRs1;
    logic [renameWidth-1:0][aregWidth-1:0]  grpRs2;
    logic [renameWidth-1:0]                 grpHasRd;
    logic [allocWidth-1:0]                  allocNum;
    logic                                   short;
    logic                                   fire;
    logic [renameWidth-1:0][pregWidth-1:0]  allocPrd;
    logic [commitWidth-1:0]                 relValid;
    logic [commitWidth-1:0][pregWidth-1:0]  relPrd;

    renameInput uInput (
        .clk, .rst,
        .inValid, .inRd, .inRs1, .inRs2, .inHasRd, .inReady,
        .grpValid, .grpRd, .grpRs1, .grpRs2, .grpHasRd,
        .allocNum, .short, .outReady
    );

    mapTable uMap (
        .clk, .rst,
        .grpValid, .grpRd, .grpRs1, .grpRs2, .grpHasRd,
        .allocPrd, .short, .outReady,
        .fire, .outValid, .outPrd, .outPrs1, .outPrs2
    );

    freeList uFree (
        .clk, .rst,
        .allocNum, .fire, .short, .allocPrd,
        .relValid, .relPrd
    );

    retireRelease uRetire (
        .clk, .rst,
        .cmtValid, .cmtRd, .cmtPrd,
        .relValid, .relPrd
    );

endmodule

`default_nettype wire

// File: rtl/retireRelease.sv
`timescale 1ns/100ps
`default_nettype none

module retireRelease (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [renamePkg::commitWidth-1:0]                       cmtValid,
    input  logic [renamePkg::commitWidth-1:0][renamePkg::aregWidth-1:0] cmtRd,
    input  logic [renamePkg::commitWidth-1:0][renamePkg::pregWidth-1:0] cmtPrd,
    output logic [renamePkg::commitWidth-1:0]                       relValid,
    output logic [renamePkg::commitWidth-1:0][renamePkg::pregWidth-1:0] relPrd
);
    import renamePkg::*;

    logic [pregWidth-1:0] cmtMap [archRegs];
    logic [commitWidth-1:0][pregWidth-1:0] oldPrd;

    // Superseded register per lane
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            oldPrd[i] = cmtMap[cmtRd[i]];
            for (int j = 0; j < i; j++) begin
                if (cmtValid[j] && cmtRd[j] == cmtRd[i]) begin
                    oldPrd[i] = cmtPrd[j];  // Same rd retired by an older lane
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < archRegs; i++) begin
                cmtMap[i] <= pregWidth'(i);
            end
            relValid <= '0;
        end else begin
            relValid <= cmtValid;
            for (int i = 0; i < commitWidth; i++) begin
                if (cmtValid[i]) begin
                    cmtMap[cmtRd[i]] <= cmtPrd[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        relPrd <= oldPrd;
    end

    // A retirement never frees the register it commits
    generate
        for (genvar i = 0; i < commitWidth; i++) begin : gCmtCheck
            assert property (@(posedge clk) disable iff (rst)
                cmtValid[i] |-> cmtPrd[i] != oldPrd[i])
                else $error("retireRelease: commit lane %0d frees its own register", i);
        end
    endgenerate

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the rename testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module renameTb -o renameSim

./obj_dir/renameSim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: sources.f
rtl/renamePkg.sv
rtl/renameInput.sv
rtl/freeList.sv
rtl/mapTable.sv
rtl/retireRelease.sv
rtl/renameTop.sv
verif/clockGen.sv
verif/renameTb.sv

// File: verif/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/renameStim.txt
// inV hasRd rd0 rd1 rs1_0 rs1_1 rs2_0 rs2_1 oRdy cmtV cRd0 cRd1 cPrd0 cPrd1
// chk expV prd0 prd1 prs1_0 prs1_1 prs2_0 prs2_1   (ff = not checked)
3 3 01 02 02 01 03 04 1 0 00 00 00 00 1 0 ff ff ff ff ff ff
3 1 03 00 01 03 02 05 1 0 00 00 00 00 1 3 20 21 02 20 03 04
3 3 01 01 01 01 03 02 1 0 00 00 00 00 1 3 22 ff 20 22 21 05
1 1 04 00 01 00 01 00 1 0 00 00 00 00 1 3 23 24 20 23 22 21
0 0 00 00 00 00 00 00 0 0 00 00 00 00 1 1 25 ff 24 ff 24 ff
0 0 00 00 00 00 00 00 0 0 00 00 00 00 1 1 25 ff 24 ff 24 ff
3 3 04 05 04 04 01 03 1 0 00 00 00 00 1 1 25 ff 24 ff 24 ff
3 3 06 07 00 06 00 1f 1 0 00 00 00 00 1 3 26 27 25 26 24 22
3 3 08 09 00 08 00 1f 1 0 00 00 00 00 1 3 28 29 00 28 00 1f
3 3 0a 0b 00 0a 00 1f 1 0 00 00 00 00 1 3 2a 2b 00 2a 00 1f
3 3 0c 0d 00 0c 00 1f 1 0 00 00 00 00 1 3 2c 2d 00 2c 00 1f
3 3 0e 0f 00 0e 00 1f 1 0 00 00 00 00 1 3 2e 2f 00 2e 00 1f
3 3 10 11 00 10 00 1f 1 0 00 00 00 00 1 3 30 31 00 30 00 1f
3 3 12 13 00 12 00 1f 1 0 00 00 00 00 1 3 32 33 00 32 00 1f
3 3 14 15 00 14 00 1f 1 0 00 00 00 00 1 3 34 35 00 34 00 1f
3 3 16 17 00 16 00 1f 1 0 00 00 00 00 1 3 36 37 00 36 00 1f
3 3 18 19 00 18 00 1f 1 0 00 00 00 00 1 3 38 39 00 38 00 1f
3 3 1a 1b 00 1a 00 1f 1 0 00 00 00 00 1 3 3a 3b 00 3a 00 1f
3 3 1c 1d 00 1c 00 1f 1 0 00 00 00 00 1 3 3c 3d 00 3c 00 1f
1 1 01 00 04 00 05 00 1 0 00 00 00 00 1 3 3e 3f 00 3e 00 1f
0 0 00 00 00 00 00 00 1 3 01 02 20 21 1 0 ff ff ff ff ff ff
0 0 00 00 00 00 00 00 1 1 03 00 22 00 1 0 ff ff ff ff ff ff
3 3 06 07 01 06 03 01 1 3 01 01 23 24 1 1 01 ff 26 ff 27 ff
3 3 08 09 00 08 00 1f 1 0 00 00 00 00 1 3 02 03 01 02 22 01
0 0 00 00 00 00 00 00 1 0 00 00 00 00 1 3 20 23 00 20 00 1f
0 0 00 00 00 00 00 00 1 0 00 00 00 00 1 0 ff ff ff ff ff ff

// File: verif/renameTb.sv
`timescale 1ns/100ps
`default_nettype none

module renameTb;
    import renamePkg::*;

    localparam int fieldCount = 22;
    localparam int maxLines   = 64;
    localparam int clkPeriod  = 8;

    logic clk;
    logic rst;

    logic [renameWidth-1:0]                 inValid;
    logic [renameWidth-1:0][aregWidth-1:0]  inRd;
    logic [renameWidth-1:0][aregWidth-1:0]  inRs1;
    logic [renameWidth-1:0][aregWidth-1:0]  inRs2;
    logic [renameWidth-1:0]                 inHasRd;
    logic                                   inReady;
    logic [renameWidth-1:0]                 outValid;
    logic [renameWidth-1:0][pregWidth-1:0]  outPrd;
    logic [renameWidth-1:0][pregWidth-1:0]  outPrs1;
    logic [renameWidth-1:0][pregWidth-1:0]  outPrs2;
    logic                                   outReady;
    logic [commitWidth-1:0]                 cmtValid;
    logic [commitWidth-1:0][aregWidth-1:0]  cmtRd;
    logic [commitWidth-1:0][pregWidth-1:0]  cmtPrd;

    logic [7:0] stim [maxLines*fieldCount];
    int         lineCount;
    logic       loaded;
    logic       held;    // Holding stage occupied, as seen from the stimulus

    clockGen uClk (.clk, .rst);

    renameTop dut (
        .clk, .rst,
        .inValid, .inRd, .inRs1, .inRs2, .inHasRd, .inReady,
        .outValid, .outPrd, .outPrs1, .outPrs2, .outReady,
        .cmtValid, .cmtRd, .cmtPrd
    );

    task automatic checkValue(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One stimulus line, driven just after the rising edge
    task automatic applyLine(input int k);
        int b;
        b = k * fieldCount;
        inValid    <= stim[b][1:0];
        inHasRd    <= stim[b+1][1:0];
        inRd[0]    <= stim[b+2][4:0];
        inRd[1]    <= stim[b+3][4:0];
        inRs1[0]   <= stim[b+4][4:0];
        inRs1[1]   <= stim[b+5][4:0];
        inRs2[0]   <= stim[b+6][4:0];
        inRs2[1]   <= stim[b+7][4:0];
        outReady   <= stim[b+8][0];
        cmtValid   <= stim[b+9][1:0];
        cmtRd[0]   <= stim[b+10][4:0];
        cmtRd[1]   <= stim[b+11][4:0];
        cmtPrd[0]  <= stim[b+12][5:0];
        cmtPrd[1]  <= stim[b+13][5:0];
    endtask

    // Expected value ff means the field is not checked
    task automatic checkLane(input string name, input int actual, input logic [7:0] expected);
        if (expected != 8'hff) begin
            checkValue(name, actual, int'(expected));
        end
    endtask

    task automatic checkLine(input int k);
        int   b;
        logic leaves;
        logic ready;
        b      = k * fieldCount;
        leaves = stim[b+15][0] && stim[b+8][0];
        ready  = !held || leaves;    // Empty stage, or its group leaves on this edge
        checkValue("inReady", int'(inReady), int'(ready));
        if (stim[b+14] != 8'h00) begin
            checkValue("outValid", int'(outValid), int'(stim[b+15][1:0]));
            checkLane("outPrd[0]", int'(outPrd[0]), stim[b+16]);
            checkLane("outPrd[1]", int'(outPrd[1]), stim[b+17]);
            checkLane("outPrs1[0]", int'(outPrs1[0]), stim[b+18]);
            checkLane("outPrs1[1]", int'(outPrs1[1]), stim[b+19]);
            checkLane("outPrs2[0]", int'(outPrs2[0]), stim[b+20]);
            checkLane("outPrs2[1]", int'(outPrs2[1]), stim[b+21]);
        end
        if (stim[b][0] && ready) begin
            held = 1'b1;
        end else if (leaves) begin
            held = 1'b0;
        end
    endtask

    initial begin
        inValid  = '0;
        inRd     = '0;
        inRs1    = '0;
        inRs2    = '0;
        inHasRd  = '0;
        outReady = 1'b0;
        cmtValid = '0;
        cmtRd    = '0;
        cmtPrd   = '0;
        loaded   = 1'b0;
        held     = 1'b0;

        for (int i = 0; i < maxLines * fieldCount; i++) begin
            stim[i] = 8'hff;
        end
        $readmemh("verif/renameStim.txt", stim);
        lineCount = 0;
        while (lineCount < maxLines && stim[lineCount*fieldCount] != 8'hff) begin
            lineCount++;
        end
        loaded = 1'b1;

        @(negedge rst);
        for (int k = 0; k < lineCount; k++) begin
            @(posedge clk);
            applyLine(k);
            @(negedge clk);    // Outputs settled mid cycle
            checkLine(k);
        end

        @(posedge clk);
        inValid  <= '0;
        cmtValid <= '0;
        $display("All tests passed");
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        #(clkPeriod * lineCount * 4 + clkPeriod * 5);
        $display("Timeout: the run did not finish in time");
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
